// File: Makefile
TOP = odd_pipe_tb

.PHONY: all build lint clean

all: build
	@out=$$(./obj_dir/V$(TOP)); \
	echo "$$out"; \
	echo "$$out" | grep -q "Simulation PASSED"

build:
	verilator --binary --timing --assert --timescale 1ns/1ps \
		-f odd_pipe.f --top-module $(TOP)

lint:
	verilator --lint-only --timing --assert --timescale 1ns/1ps \
		-f odd_pipe.f --top-module $(TOP)

clean:
	rm -rf obj_dir

// File: hdl/branch_unit.sv
`include "spu_cfg.svh"

module branch_unit
    import spu_isa_pkg::*, spu_pipe_pkg::*;
(
    input  br_ctl_t                br_ctl,
    input  logic [0:`WORD_W-1]     rb_word,
    input  logic [0:`WORD_W-1]     pc,
    input  logic [0:`RT_ADDR_W-1]  rt_addr,
    output fwd_entry_t             entry,
    output logic                   branch_taken,
    output logic [0:`WORD_W-1]     pc_out
);

    logic                cond_met;
    logic [0:`WORD_W-1]  pc_plus4;
    logic [0:`WORD_W-1]  jump;
    logic [0:`WORD_W-1]  target;

    // halfword tests look at the low half of the preferred word
    always_comb
    begin
        case (br_ctl.cond)
            bc_always:    cond_met = 1'b1;
            bc_word_zero: cond_met = (rb_word == '0);
            bc_word_nz:   cond_met = (rb_word != '0);
            bc_half_zero: cond_met = (rb_word[`WORD_W/2:`WORD_W-1] == '0);
            bc_half_nz:   cond_met = (rb_word[`WORD_W/2:`WORD_W-1] != '0);
            default:      cond_met = 1'b0;
        endcase
    end

    assign pc_plus4 = pc + `WORD_W'd4;
    assign jump     = br_ctl.absolute ? br_ctl.offset : pc + br_ctl.offset;

    // conditional forms drop the low two target bits
    assign target = (br_ctl.cond == bc_always) ? jump : {jump[0:`WORD_W-3], 2'b00};

    assign branch_taken = br_ctl.en & cond_met;
    assign pc_out       = branch_taken ? target : pc_plus4;

    // link value is the return address in the preferred word
    always_comb
    begin
        entry = '0;
        if (br_ctl.en)
        begin
            entry.unit_id = `BR_UNIT_ID;
            entry.wr_en   = br_ctl.link;
            entry.rt_addr = rt_addr;
            entry.latency = `BR_LATENCY;
            if (br_ctl.link)
            begin
                entry.rt_value[0:`WORD_W-1] = pc_plus4;
            end
        end
    end

endmodule

// File: hdl/forward_pipe.sv
`include "spu_cfg.svh"

module forward_pipe
    import spu_pipe_pkg::*;
(
    input  logic         clock,
    input  logic         reset,
    input  logic         flush,
    input  fwd_entry_t   perm_entry,
    input  fwd_entry_t   br_entry,
    output fwd_stages_t  fwd_st
);

    fwd_entry_t                     stage1;
    fwd_entry_t [2:`FWD_STAGES]     stage_q;

    // idle units drive all zero, so an OR picks the active one
    assign stage1 = perm_entry | br_entry;

    always_ff @(posedge clock)
    begin
        if (reset)
        begin
            stage_q <= '0;
        end
        else
        begin
            // flush kills only the entry leaving stage 1
            if (flush)
                stage_q[2] <= '0;
            else
                stage_q[2] <= stage1;
            for (int k = 3; k <= `FWD_STAGES; k++)
            begin
                stage_q[k] <= stage_q[k-1];
            end
        end
    end

    // stage 1 sits in the leftmost slot of the array
    assign fwd_st = {stage1, stage_q};

endmodule

// File: hdl/odd_issue_stage.sv
`include "spu_cfg.svh"

module odd_issue_stage
    import spu_isa_pkg::*;
(
    input  logic                   clock,
    input  logic                   reset,
    input  odd_instr_t             instr,
    input  logic [0:`RT_ADDR_W-1]  rt_addr,
    output perm_ctl_t              perm_ctl,
    output br_ctl_t                br_ctl,
    output logic [0:`QUAD_W-1]     ra_q,
    output logic [0:`WORD_W-1]     rb_word,
    output logic [0:`WORD_W-1]     pc_q,
    output logic [0:`RT_ADDR_W-1]  rt_addr_q
);

    odd_instr_t          instr_q;
    logic [4:0]          rb_cnt;
    logic [4:0]          i7_cnt;
    logic [0:`WORD_W-1]  br_offset;

    function automatic perm_ctl_t perm_sel(input perm_kind_t kind, input logic [4:0] count);
        perm_ctl_t ctl;
        ctl.en = 1'b1;
        ctl.kind = kind;
        ctl.count = count;
        return ctl;
    endfunction

    function automatic br_ctl_t br_sel(input logic absolute, input logic link,
                                       input br_cond_t cond, input logic [0:`WORD_W-1] offset);
        br_ctl_t ctl;
        ctl.en = 1'b1;
        ctl.absolute = absolute;
        ctl.link = link;
        ctl.cond = cond;
        ctl.offset = offset;
        return ctl;
    endfunction

    // rt address arrives on its own issue port
    always_ff @(posedge clock)
    begin
        instr_q <= instr;
        instr_q.rt <= rt_addr;
        if (reset)
            instr_q.op <= op_nop;
    end

    assign ra_q      = instr_q.ra;
    assign rb_word   = instr_q.rb[0:`WORD_W-1];
    assign pc_q      = instr_q.pc;
    assign rt_addr_q = instr_q.rt;

    // low five bits of the preferred word and of the immediate
    assign rb_cnt = instr_q.rb[`WORD_W-5:`WORD_W-1];
    assign i7_cnt = instr_q.i7[`I7_W-5:`I7_W-1];

    // word offset to byte offset, sign extended
    assign br_offset = {{(`WORD_W-`I16_W-2){instr_q.i16[0]}}, instr_q.i16, 2'b00};

    always_comb
    begin
        perm_ctl = '0;
        br_ctl = '0;
        case (instr_q.op)
            op_shlqbi:  perm_ctl = perm_sel(pk_shl_bits, {2'b00, rb_cnt[2:0]});
            op_shlqbii: perm_ctl = perm_sel(pk_shl_bits, {2'b00, i7_cnt[2:0]});
            op_shlqby:  perm_ctl = perm_sel(pk_shl_bytes, rb_cnt);
            op_shlqbyi: perm_ctl = perm_sel(pk_shl_bytes, i7_cnt);
            op_rotqbi:  perm_ctl = perm_sel(pk_rot_bits, {2'b00, rb_cnt[2:0]});
            op_rotqbii: perm_ctl = perm_sel(pk_rot_bits, {2'b00, i7_cnt[2:0]});
            op_rotqby:  perm_ctl = perm_sel(pk_rot_bytes, {1'b0, rb_cnt[3:0]});
            op_rotqbyi: perm_ctl = perm_sel(pk_rot_bytes, {1'b0, i7_cnt[3:0]});
            op_gbb:     perm_ctl = perm_sel(pk_gather_bytes, 5'd0);
            op_gbh:     perm_ctl = perm_sel(pk_gather_halves, 5'd0);
            op_gb:      perm_ctl = perm_sel(pk_gather_words, 5'd0);
            op_br:      br_ctl = br_sel(1'b0, 1'b0, bc_always, br_offset);
            op_bra:     br_ctl = br_sel(1'b1, 1'b0, bc_always, br_offset);
            op_brsl:    br_ctl = br_sel(1'b0, 1'b1, bc_always, br_offset);
            op_brasl:   br_ctl = br_sel(1'b1, 1'b1, bc_always, br_offset);
            op_brz:     br_ctl = br_sel(1'b0, 1'b0, bc_word_zero, br_offset);
            op_brnz:    br_ctl = br_sel(1'b0, 1'b0, bc_word_nz, br_offset);
            op_brhz:    br_ctl = br_sel(1'b0, 1'b0, bc_half_zero, br_offset);
            op_brhnz:   br_ctl = br_sel(1'b0, 1'b0, bc_half_nz, br_offset);
            default:
            begin
                perm_ctl = '0;
                br_ctl = '0;
            end
        endcase
    end

endmodule

// File: hdl/odd_pipe.sv
`include "spu_cfg.svh"

module odd_pipe
    import spu_isa_pkg::*, spu_pipe_pkg::*;
(
    input  logic                   clock,
    input  logic                   reset,
    input  odd_instr_t             instr,
    input  logic [0:`RT_ADDR_W-1]  rt_addr,
    input  logic                   flush,
    output fwd_stages_t            fwd_st,
    output logic                   branch_taken,
    output logic [0:`WORD_W-1]     pc_out
);

    perm_ctl_t              perm_ctl;
    br_ctl_t                br_ctl;
    logic [0:`QUAD_W-1]     ra_q;
    logic [0:`WORD_W-1]     rb_word;
    logic [0:`WORD_W-1]     pc_q;
    logic [0:`RT_ADDR_W-1]  rt_addr_q;
    fwd_entry_t             perm_entry;
    fwd_entry_t             br_entry;

    odd_issue_stage u_issue (
        .clock     (clock),
        .reset     (reset),
        .instr     (instr),
        .rt_addr   (rt_addr),
        .perm_ctl  (perm_ctl),
        .br_ctl    (br_ctl),
        .ra_q      (ra_q),
        .rb_word   (rb_word),
        .pc_q      (pc_q),
        .rt_addr_q (rt_addr_q)
    );

    permute_unit u_perm (
        .perm_ctl (perm_ctl),
        .ra       (ra_q),
        .rt_addr  (rt_addr_q),
        .entry    (perm_entry)
    );

    branch_unit u_branch (
        .br_ctl       (br_ctl),
        .rb_word      (rb_word),
        .pc           (pc_q),
        .rt_addr      (rt_addr_q),
        .entry        (br_entry),
        .branch_taken (branch_taken),
        .pc_out       (pc_out)
    );

    forward_pipe u_fwd (
        .clock      (clock),
        .reset      (reset),
        .flush      (flush),
        .perm_entry (perm_entry),
        .br_entry   (br_entry),
        .fwd_st     (fwd_st)
    );

endmodule

// File: hdl/permute_unit.sv
`include "spu_cfg.svh"

module permute_unit
    import spu_isa_pkg::*, spu_pipe_pkg::*;
(
    input  perm_ctl_t              perm_ctl,
    input  logic [0:`QUAD_W-1]     ra,
    input  logic [0:`RT_ADDR_W-1]  rt_addr,
    output fwd_entry_t             entry
);

    logic [0:`QUAD_W-1]  rt_value;
    logic [7:0]          bit_sh;
    logic [7:0]          byte_sh;
    logic [0:15]         g_bytes;
    logic [0:7]          g_halves;
    logic [0:3]          g_words;

    // shift amounts in bits, byte forms scale the count by 8
    assign bit_sh  = {3'b000, perm_ctl.count};
    assign byte_sh = {perm_ctl.count, 3'b000};

    // lsb of every element, element 0 lands in the msb
    always_comb
    begin
        for (int j = 0; j < 16; j++)
        begin
            g_bytes[j] = ra[j*8 + 7];
        end
        for (int j = 0; j < 8; j++)
        begin
            g_halves[j] = ra[j*16 + 15];
        end
        for (int j = 0; j < 4; j++)
        begin
            g_words[j] = ra[j*32 + 31];
        end
    end

    // bit 0 is the msb, so a left shift moves data toward bit 0
    always_comb
    begin
        rt_value = '0;
        case (perm_ctl.kind)
            pk_shl_bits:
            begin
                rt_value = ra << bit_sh;
            end
            pk_shl_bytes:
            begin
                // counts of 16 bytes and up shift everything out
                rt_value = ra << byte_sh;
            end
            pk_rot_bits:
            begin
                rt_value = (ra << bit_sh) | (ra >> (8'd128 - bit_sh));
            end
            pk_rot_bytes:
            begin
                rt_value = (ra << byte_sh) | (ra >> (8'd128 - byte_sh));
            end
            pk_gather_bytes:
            begin
                rt_value[0:`WORD_W-1] = {16'd0, g_bytes};
            end
            pk_gather_halves:
            begin
                rt_value[0:`WORD_W-1] = {24'd0, g_halves};
            end
            pk_gather_words:
            begin
                rt_value[0:`WORD_W-1] = {28'd0, g_words};
            end
            default:
            begin
                rt_value = '0;
            end
        endcase
    end

    always_comb
    begin
        entry = '0;
        if (perm_ctl.en)
        begin
            entry.unit_id  = `PERM_UNIT_ID;
            entry.rt_value = rt_value;
            entry.wr_en    = 1'b1;
            entry.rt_addr  = rt_addr;
            entry.latency  = `PERM_LATENCY;
        end
    end

endmodule

// File: hdl/spu_cfg.svh
`ifndef SPU_CFG_SVH
`define SPU_CFG_SVH

// datapath widths
`define QUAD_W        128
`define WORD_W        32

// forwarding network depth
`define FWD_STAGES    7

// instruction field widths
`define OP_W          6
`define RT_ADDR_W     7
`define I7_W          7
`define I16_W         16

// forwarding entry fields
`define UNIT_ID_W     3
`define LAT_W         4

// unit ids of the odd pipe
`define PERM_UNIT_ID  3'd5
`define BR_UNIT_ID    3'd7

// result latencies in cycles
`define PERM_LATENCY  4'd4
`define BR_LATENCY    4'd1

`endif

// File: hdl/spu_isa_pkg.sv
`include "spu_cfg.svh"

package spu_isa_pkg;

    // odd pipe opcodes, nop issues nothing
    typedef enum logic [`OP_W-1:0] {
        op_nop,
        op_shlqbi,
        op_shlqbii,
        op_shlqby,
        op_shlqbyi,
        op_rotqbi,
        op_rotqbii,
        op_rotqby,
        op_rotqbyi,
        op_gbb,
        op_gbh,
        op_gb,
        op_br,
        op_bra,
        op_brsl,
        op_brasl,
        op_brz,
        op_brnz,
        op_brhz,
        op_brhnz
    } odd_op_t;

    // instruction as presented at the issue port
    typedef struct packed {
        odd_op_t                op;
        logic [0:`RT_ADDR_W-1]  rt;
        logic [0:`I7_W-1]       i7;
        logic [0:`I16_W-1]      i16;
        logic [0:`QUAD_W-1]     ra;
        logic [0:`QUAD_W-1]     rb;
        logic [0:`WORD_W-1]     pc;
    } odd_instr_t;

    typedef enum logic [2:0] {
        pk_shl_bits,
        pk_shl_bytes,
        pk_rot_bits,
        pk_rot_bytes,
        pk_gather_bytes,
        pk_gather_halves,
        pk_gather_words
    } perm_kind_t;

    // count is in bits or bytes depending on kind
    typedef struct packed {
        logic        en;
        perm_kind_t  kind;
        logic [4:0]  count;
    } perm_ctl_t;

    typedef enum logic [2:0] {
        bc_always,
        bc_word_zero,
        bc_word_nz,
        bc_half_zero,
        bc_half_nz
    } br_cond_t;

    // offset is already a sign extended byte offset
    typedef struct packed {
        logic                en;
        logic                absolute;
        logic                link;
        br_cond_t            cond;
        logic [0:`WORD_W-1]  offset;
    } br_ctl_t;

endpackage

// File: hdl/spu_pipe_pkg.sv
`include "spu_cfg.svh"

package spu_pipe_pkg;

    // one result in flight on the forwarding network
    typedef struct packed {
        logic [0:`UNIT_ID_W-1]  unit_id;
        logic [0:`QUAD_W-1]     rt_value;
        logic                   wr_en;
        logic [0:`RT_ADDR_W-1]  rt_addr;
        logic [0:`LAT_W-1]      latency;
    } fwd_entry_t;

    // stage 1 is the leftmost element
    typedef fwd_entry_t [1:`FWD_STAGES] fwd_stages_t;

endpackage

// File: odd_pipe.f
+incdir+hdl
hdl/spu_isa_pkg.sv
hdl/spu_pipe_pkg.sv
hdl/odd_issue_stage.sv
hdl/permute_unit.sv
hdl/branch_unit.sv
hdl/forward_pipe.sv
hdl/odd_pipe.sv
sim/odd_pipe_tb.sv

// File: sim/odd_pipe_tb.sv
`include "spu_cfg.svh"

module odd_pipe_tb
    import spu_isa_pkg::*, spu_pipe_pkg::*;
;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int CLK_PERIOD = 20;
    localparam int unsigned SEED = 32'hfd0b1c88;
    localparam odd_op_t SHIFT_OPS [0:7] = '{op_shlqbi, op_shlqbii, op_shlqby, op_shlqbyi,
                                            op_rotqbi, op_rotqbii, op_rotqby, op_rotqbyi};
    localparam odd_op_t GATHER_OPS [0:2] = '{op_gbb, op_gbh, op_gb};
    localparam odd_op_t UNCOND_OPS [0:3] = '{op_br, op_bra, op_brsl, op_brasl};
    localparam odd_op_t COND_OPS [0:3] = '{op_brz, op_brnz, op_brhz, op_brhnz};

    logic         clock;
    logic         reset;
    odd_instr_t   instr;
    logic [6:0]   rt_addr;
    logic         flush;
    fwd_stages_t  fwd_st;
    logic         branch_taken;
    logic [31:0]  pc_out;

    // expected contents of stages 1 to 7
    fwd_entry_t   model [0:6];
    int           checks;
    int           errors;
    int           tests_run;
    int           tests_failed;
    int           errors_at_start;
    string        cur_test;
    event         clock_stalled;

    odd_pipe uut (
        .clock        (clock),
        .reset        (reset),
        .instr        (instr),
        .rt_addr      (rt_addr),
        .flush        (flush),
        .fwd_st       (fwd_st),
        .branch_taken (branch_taken),
        .pc_out       (pc_out)
    );

    initial
    begin
        clock = 1'b0;
        forever #(CLK_PERIOD / 2) clock = ~clock;
    end

    initial
    begin
        @(clock_stalled);
        $display("no falling clock edge arrived within the timeout");
        $display("Simulation FAILED");
        $finish;
    end

    // each falling edge is awaited against its own timeout
    task automatic wait_falls(input int n);
        bit timed_out;
        for (int i = 0; i < n; i++)
        begin
            timed_out = 1'b0;
            fork
                @(negedge clock);
                begin
                    #(2 * CLK_PERIOD);
                    timed_out = 1'b1;
                end
            join_any
            disable fork;
            if (timed_out)
            begin
                errors++;
                -> clock_stalled;
            end
        end
    endtask

    function automatic logic [127:0] rand_quad();
        return {$urandom, $urandom, $urandom, $urandom};
    endfunction

    function automatic odd_instr_t rand_instr(input odd_op_t op);
        odd_instr_t ins;
        ins.op = op;
        ins.rt = 7'($urandom);
        ins.i7 = 7'($urandom);
        ins.i16 = 16'($urandom);
        ins.ra = rand_quad();
        ins.rb = rand_quad();
        ins.pc = $urandom;
        return ins;
    endfunction

    // numeric left means toward bit 0 of the quadword
    function automatic logic [127:0] shift_left(input logic [127:0] v, input int n);
        logic [127:0] r;
        r = '0;
        for (int i = 0; i < 128; i++)
        begin
            if (i >= n)
                r[i] = v[i - n];
        end
        return r;
    endfunction

    function automatic logic [127:0] rotate_left(input logic [127:0] v, input int n);
        logic [127:0] r;
        for (int i = 0; i < 128; i++)
        begin
            r[i] = v[(i - n + 128) % 128];
        end
        return r;
    endfunction

    // element 0 is the most significant element and lands in the top result bit
    function automatic logic [31:0] gather_lsbs(input logic [127:0] v, input int elem_bits);
        logic [31:0] r;
        int count;
        r = '0;
        count = 128 / elem_bits;
        for (int j = 0; j < count; j++)
        begin
            r[count - 1 - j] = v[127 - (j * elem_bits + elem_bits - 1)];
        end
        return r;
    endfunction

    function automatic fwd_entry_t ref_entry(input odd_instr_t ins);
        fwd_entry_t e;
        logic [127:0] ra;
        logic [127:0] rb;
        logic [31:0] rbw;
        logic [6:0] i7;
        logic [127:0] val;
        e = '0;
        ra = ins.ra;
        rb = ins.rb;
        rbw = rb[127:96];
        i7 = ins.i7;
        case (ins.op)
            op_shlqbi:  val = shift_left(ra, int'(rbw[2:0]));
            op_shlqbii: val = shift_left(ra, int'(i7[2:0]));
            op_shlqby:  val = shift_left(ra, 8 * int'(rbw[4:0]));
            op_shlqbyi: val = shift_left(ra, 8 * int'(i7[4:0]));
            op_rotqbi:  val = rotate_left(ra, int'(rbw[2:0]));
            op_rotqbii: val = rotate_left(ra, int'(i7[2:0]));
            op_rotqby:  val = rotate_left(ra, 8 * int'(rbw[3:0]));
            op_rotqbyi: val = rotate_left(ra, 8 * int'(i7[3:0]));
            op_gbb:     val = {gather_lsbs(ra, 8), 96'd0};
            op_gbh:     val = {gather_lsbs(ra, 16), 96'd0};
            op_gb:      val = {gather_lsbs(ra, 32), 96'd0};
            op_brsl, op_brasl: val = {ins.pc + 32'd4, 96'd0};
            default:    val = '0;
        endcase
        if (ins.op != op_nop)
        begin
            e.rt_value = val;
            e.rt_addr = ins.rt;
            if (ins.op inside {op_br, op_bra, op_brsl, op_brasl,
                               op_brz, op_brnz, op_brhz, op_brhnz})
            begin
                e.unit_id = `BR_UNIT_ID;
                e.latency = `BR_LATENCY;
                e.wr_en = (ins.op inside {op_brsl, op_brasl});
            end
            else
            begin
                e.unit_id = `PERM_UNIT_ID;
                e.latency = `PERM_LATENCY;
                e.wr_en = 1'b1;
            end
        end
        return e;
    endfunction

    function automatic void ref_branch(input odd_instr_t ins, output logic taken,
                                       output logic [31:0] next_pc);
        logic [127:0] rb;
        logic [31:0] rbw;
        logic [31:0] off;
        logic [31:0] dest;
        rb = ins.rb;
        rbw = rb[127:96];
        off = {{14{ins.i16[0]}}, ins.i16, 2'b00};
        dest = ins.pc + off;
        case (ins.op)
            op_br, op_brsl: taken = 1'b1;
            op_bra, op_brasl:
            begin
                taken = 1'b1;
                dest = off;
            end
            op_brz:   taken = (rbw == 32'd0);
            op_brnz:  taken = (rbw != 32'd0);
            op_brhz:  taken = (rbw[15:0] == 16'd0);
            op_brhnz: taken = (rbw[15:0] != 16'd0);
            default:  taken = 1'b0;
        endcase
        // conditional forms land on a word boundary
        if (ins.op inside {op_brz, op_brnz, op_brhz, op_brhnz})
            dest[1:0] = 2'b00;
        next_pc = taken ? dest : ins.pc + 32'd4;
    endfunction

    task automatic check_entry(input string what, input fwd_entry_t exp, input fwd_entry_t act);
        checks++;
        assert (act === exp)
        else
        begin
            errors++;
            $display("FAILED %s %s: expected %h, actual %h", cur_test, what, exp, act);
        end
    endtask

    task automatic check_word(input string what, input logic [31:0] exp, input logic [31:0] act);
        checks++;
        assert (act === exp)
        else
        begin
            errors++;
            $display("FAILED %s %s: expected %h, actual %h", cur_test, what, exp, act);
        end
    endtask

    task automatic start_test(input string name);
        cur_test = name;
        errors_at_start = errors;
    endtask

    task automatic end_test();
        tests_run++;
        if (errors == errors_at_start)
            $display("test %s: ok", cur_test);
        else
        begin
            tests_failed++;
            $display("test %s: %0d errors", cur_test, errors - errors_at_start);
        end
    endtask

    // drive on a falling edge, check every stage on the next one
    task automatic issue_and_check(input odd_instr_t ins, input logic fl);
        logic exp_taken;
        logic [31:0] exp_pc;
        instr = ins;
        rt_addr = ins.rt;
        flush = fl;
        for (int k = 6; k >= 2; k--)
            model[k] = model[k - 1];
        model[1] = fl ? '0 : model[0];
        model[0] = ref_entry(ins);
        ref_branch(ins, exp_taken, exp_pc);
        wait_falls(1);
        for (int k = 1; k <= `FWD_STAGES; k++)
            check_entry($sformatf("%s stage %0d", ins.op.name(), k), model[k - 1], fwd_st[k]);
        if (fl)
            check_entry("flushed stage 2", '0, fwd_st[2]);
        check_word("branch_taken", {31'd0, exp_taken}, {31'd0, branch_taken});
        check_word("pc_out", exp_pc, pc_out);
    endtask

    initial
    begin
        odd_instr_t ins;
        logic [31:0] w;
        logic [6:0] i7v;
        logic fl;
        void'($urandom(SEED));
        checks = 0;
        errors = 0;
        tests_run = 0;
        tests_failed = 0;
        reset = 1'b1;
        flush = 1'b0;
        rt_addr = '0;
        // a taken link branch waits on the issue port for the whole reset
        instr = rand_instr(op_brsl);
        for (int k = 0; k < 7; k++)
            model[k] = '0;
        wait_falls(5);

        start_test("reset");
        for (int k = 1; k <= `FWD_STAGES; k++)
            check_entry($sformatf("stage %0d", k), '0, fwd_st[k]);
        check_word("branch_taken", 32'd0, {31'd0, branch_taken});
        end_test();
        reset = 1'b0;

        // counts step by 5 and wrap, so every bit count and byte shifts of 16 and more occur
        start_test("shift_rotate");
        for (int s = 0; s < 8; s++)
        begin
            for (int r = 0; r < 8; r++)
            begin
                ins = rand_instr(SHIFT_OPS[s]);
                w = $urandom;
                w[4:0] = 5'(r * 5);
                ins.rb[0:31] = w;
                i7v = 7'($urandom);
                i7v[4:0] = 5'(r * 5);
                ins.i7 = i7v;
                issue_and_check(ins, 1'b0);
            end
        end
        end_test();

        start_test("gather");
        for (int s = 0; s < 3; s++)
            for (int r = 0; r < 8; r++)
                issue_and_check(rand_instr(GATHER_OPS[s]), 1'b0);
        end_test();

        start_test("branch_uncond");
        for (int s = 0; s < 4; s++)
        begin
            for (int r = 0; r < 4; r++)
            begin
                ins = rand_instr(UNCOND_OPS[s]);
                ins.i16 = 16'($urandom) | 16'h8000;
                issue_and_check(ins, 1'b0);
            end
        end
        end_test();

        // zero word, zero halfword only, both non zero, anything
        start_test("branch_cond");
        for (int s = 0; s < 4; s++)
        begin
            for (int r = 0; r < 4; r++)
            begin
                ins = rand_instr(COND_OPS[s]);
                case (r)
                    0:       w = 32'd0;
                    1:       w = {16'($urandom) | 16'h0001, 16'h0000};
                    2:       w = $urandom | 32'h0000_0001;
                    default: w = $urandom;
                endcase
                ins.rb[0:31] = w;
                issue_and_check(ins, 1'b0);
            end
        end
        end_test();

        start_test("stream");
        for (int i = 0; i < 40; i++)
            issue_and_check(rand_instr(odd_op_t'(6'($urandom_range(19, 0)))), 1'b0);
        end_test();

        start_test("flush");
        for (int i = 0; i < 24; i++)
        begin
            fl = (i == 6) || (i == 13) || (i == 14) || (i == 20);
            issue_and_check(rand_instr(odd_op_t'(6'($urandom_range(19, 1)))), fl);
        end
        for (int i = 0; i < 8; i++)
            issue_and_check(rand_instr(op_nop), 1'b0);
        end_test();

        $display("tests: %0d run, %0d failed, checks: %0d, errors: %0d",
                 tests_run, tests_failed, checks, errors);
        if (errors == 0)
            $display("Simulation PASSED");
        else
            $display("Simulation FAILED");
        $finish;
    end

endmodule
